// File: vec_backend.f
design/vec_cfg_pkg.sv
design/vec_uop_pkg.sv
design/alu_issue_if.sv
design/cmd_queue.sv
design/vec_vrf.sv
design/vec_dispatch.sv
design/vec_alu.sv
design/vec_backend.sv
tb/vec_backend_assertions.sv
tb/vec_backend_tb.sv

// File: Makefile
TOP := vec_backend_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vec_backend.f $(wildcard design/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert -f vec_backend.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f vec_backend.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/vec_backend_tests.txt
# name  then per lane: valid opcode vd vs1 vs2 scalar(hex)
# opcodes: 0 vadd, 1 vsub, 2 vand, 3 vor, 4 vxor, 5 vmv_vx
reset_zero_a 1 0 1 2 3 00 0 0 0 0 0 00
reset_zero_b 1 0 4 30 31 00 1 0 5 6 7 00
splat_a 1 5 10 3 4 3c 1 5 11 0 0 f0
splat_b 1 5 12 0 0 ff 0 0 0 0 0 00
add_wrap 1 0 13 10 11 00 1 0 14 11 12 00
sub_wrap 1 1 15 11 10 00 1 1 16 12 10 00
splat_c 1 5 8 0 0 a5 1 5 9 0 0 5a
logic_and 1 2 17 12 11 00 1 2 7 8 14 00
logic_or 1 3 18 10 11 00 1 3 6 8 9 00
logic_xor 1 4 19 13 14 00 1 4 3 8 8 00
logic_mix 1 4 2 15 16 00 0 0 0 0 0 00
dep_chain_a 1 5 20 0 0 01 1 0 21 20 20 00
dep_chain_b 1 0 22 21 20 00 1 1 23 22 21 00
dep_chain_c 1 4 24 23 22 00 1 2 25 24 24 00
dep_chain_d 1 0 20 25 21 00 0 0 0 0 0 00
dep_chain_e 1 1 21 20 20 00 1 3 22 21 13 00
burst_0 1 0 26 20 21 00 1 0 27 26 22 00
burst_1 1 1 28 27 26 00 1 0 29 28 27 00
burst_2 1 4 30 29 28 00 1 0 31 30 29 00
burst_3 1 0 26 31 30 00 1 1 27 26 31 00
burst_4 1 3 28 27 26 00 1 0 29 28 10 00
burst_5 1 0 30 29 28 00 1 4 31 30 11 00
burst_6 1 1 26 31 30 00 1 0 27 26 26 00
burst_7 1 5 28 0 0 7e 1 0 29 28 27 00
final_a 1 3 0 29 29 00 1 3 1 31 31 00
final_b 1 0 5 27 13 00 0 0 0 0 0 00

// File: tb/vec_backend_tb.sv
`timescale 1ns/100ps
`default_nettype none

module vec_backend_tb;

    logic                              clk;
    logic                              rst_n;
    logic [1:0]                        insts_valid;
    vec_uop_pkg::vec_cmd_t [1:0]       insts_cmd;
    logic [1:0]                        insts_ready;
    logic                              rt_valid;
    vec_cfg_pkg::vreg_idx_t            rt_vd;
    vec_cfg_pkg::vreg_t                rt_data;

    // Lines from the tests file
    string                  line_name [$];
    logic [1:0]             line_valid [$];
    vec_uop_pkg::vec_cmd_t  line_cmd0 [$];
    vec_uop_pkg::vec_cmd_t  line_cmd1 [$];

    // Reference register file and expected retire stream
    vec_cfg_pkg::vreg_t     ref_regs [vec_cfg_pkg::num_vreg];
    string                  exp_name [$];
    vec_cfg_pkg::vreg_idx_t exp_vd [$];
    vec_cfg_pkg::vreg_t     exp_data [$];

    int    errors = 0;
    int    checks = 0;
    logic  loaded = 1'b0;
    logic  ready_seen = 1'b0;
    logic  saw_full = 1'b0;
    string ret_name;

    vec_backend vec_backend_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .insts_valid (insts_valid),
        .insts_cmd   (insts_cmd),
        .insts_ready (insts_ready),
        .rt_valid    (rt_valid),
        .rt_vd       (rt_vd),
        .rt_data     (rt_data)
    );

    bind vec_backend vec_backend_assertions vec_backend_assertions_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .insts_valid (insts_valid),
        .insts_ready (insts_ready),
        .rt_valid    (rt_valid)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_vd(input string name, input vec_cfg_pkg::vreg_idx_t expected,
                            input vec_cfg_pkg::vreg_idx_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: vd expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_vreg(input string name, input vec_cfg_pkg::vreg_t expected,
                              input vec_cfg_pkg::vreg_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: data expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic vec_uop_pkg::vec_cmd_t make_cmd(input int op, input int vd,
                                                       input int vs1, input int vs2,
                                                       input int scalar);
        vec_uop_pkg::vec_cmd_t cmd;
        cmd.op     = vec_uop_pkg::vec_op_e'(op[2:0]);
        cmd.vd     = vec_cfg_pkg::vreg_idx_t'(vd);
        cmd.vs1    = vec_cfg_pkg::vreg_idx_t'(vs1);
        cmd.vs2    = vec_cfg_pkg::vreg_idx_t'(vs2);
        cmd.scalar = vec_cfg_pkg::elem_t'(scalar);
        return cmd;
    endfunction

    // Per byte vs2 op vs1 with arithmetic modulo 256
    function automatic vec_cfg_pkg::vreg_t model_result(input vec_uop_pkg::vec_cmd_t cmd);
        vec_cfg_pkg::vreg_t r;
        int x;
        int y;
        for (int e = 0; e < vec_cfg_pkg::num_elems; e++) begin
            x = int'(ref_regs[cmd.vs2][e*8 +: 8]);
            y = int'(ref_regs[cmd.vs1][e*8 +: 8]);
            case (cmd.op)
                vec_uop_pkg::op_vadd:   r[e*8 +: 8] = 8'((x + y) % 256);
                vec_uop_pkg::op_vsub:   r[e*8 +: 8] = 8'((x - y + 256) % 256);
                vec_uop_pkg::op_vand:   r[e*8 +: 8] = 8'(x & y);
                vec_uop_pkg::op_vor:    r[e*8 +: 8] = 8'(x | y);
                vec_uop_pkg::op_vxor:   r[e*8 +: 8] = 8'(x ^ y);
                default:                r[e*8 +: 8] = cmd.scalar;
            endcase
        end
        return r;
    endfunction

    task automatic record_accept(input string name, input vec_uop_pkg::vec_cmd_t cmd);
        vec_cfg_pkg::vreg_t res;
        res = model_result(cmd);
        exp_name.push_back(name);
        exp_vd.push_back(cmd.vd);
        exp_data.push_back(res);
        ref_regs[cmd.vd] = res;
    endtask

    task automatic load_tests();
        int    fd;
        int    fields;
        string text;
        string name;
        int    v0, o0, d0, a0, b0, s0;
        int    v1, o1, d1, a1, b1, s1;
        fd = $fopen("tb/vec_backend_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("ERROR: cannot open tb/vec_backend_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() < 2 || text[0] == "#") begin
                continue;
            end
            fields = $sscanf(text, "%s %d %d %d %d %d %h %d %d %d %d %d %h", name,
                             v0, o0, d0, a0, b0, s0, v1, o1, d1, a1, b1, s1);
            if (fields != 13) begin
                errors++;
                $display("ERROR: malformed tests line: %s", text);
                continue;
            end
            line_name.push_back(name);
            // A line without lane 0 is an idle line
            line_valid.push_back((v0 != 0) ? {v1 != 0, 1'b1} : 2'b00);
            line_cmd0.push_back(make_cmd(o0, d0, a0, b0, s0));
            line_cmd1.push_back(make_cmd(o1, d1, a1, b1, s1));
        end
        $fclose(fd);
    endtask

    // Retire checks and ready ladder sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (insts_ready[1] && !insts_ready[0]) begin
                errors++;
                $display("ERROR: ready lane 1 high while lane 0 is low");
            end
            if (insts_ready[0]) begin
                ready_seen <= 1'b1;
            end else if (ready_seen) begin
                saw_full <= 1'b1;
            end
            if (rt_valid) begin
                if (exp_vd.size() == 0) begin
                    errors++;
                    $display("ERROR: retire of v%0d with no command outstanding", rt_vd);
                end else begin
                    ret_name = exp_name.pop_front();
                    check_vd(ret_name, exp_vd.pop_front(), rt_vd);
                    check_vreg(ret_name, exp_data.pop_front(), rt_data);
                end
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (16 * line_name.size() + 200) @(posedge clk);
        $display("ERROR: watchdog expired before all results retired");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int                          drain;
        logic [1:0]                  cur_valid;
        logic [1:0]                  acc;
        vec_uop_pkg::vec_cmd_t [1:0] cur_cmd;
        void'($urandom(67));
        rst_n = 1'b0;
        insts_valid = '0;
        insts_cmd = '0;
        for (int r = 0; r < vec_cfg_pkg::num_vreg; r++) begin
            ref_regs[r] = '0;
        end
        load_tests();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int n = 0; n < line_name.size(); n++) begin
            cur_valid = line_valid[n];
            cur_cmd[0] = line_cmd0[n];
            cur_cmd[1] = line_cmd1[n];
            while (cur_valid != 2'b00) begin
                insts_valid = cur_valid;
                insts_cmd = cur_cmd;
                @(negedge clk);
                acc = insts_valid & insts_ready;
                @(posedge clk);
                #1;
                if (acc[0]) begin
                    record_accept(line_name[n], cur_cmd[0]);
                end
                if (acc[1]) begin
                    record_accept(line_name[n], cur_cmd[1]);
                end
                if (acc == 2'b11) begin
                    cur_valid = 2'b00;
                end else if (acc == 2'b01) begin
                    // Lane 1 moves down to lane 0
                    cur_cmd[0] = cur_cmd[1];
                    cur_valid = {1'b0, cur_valid[1]};
                end else if (acc == 2'b10) begin
                    errors++;
                    $display("ERROR: %s lane 1 taken without lane 0", line_name[n]);
                    cur_valid = 2'b00;
                end
            end
            insts_valid = '0;
            if ($urandom % 4 == 0) begin
                @(posedge clk);
                #1;
            end
        end
        drain = 0;
        while (exp_vd.size() != 0 && drain < 60) begin
            @(posedge clk);
            drain++;
        end
        repeat (4) @(posedge clk);
        if (exp_vd.size() != 0) begin
            errors++;
            $display("ERROR: %0d results never retired, first from %s",
                     exp_vd.size(), exp_name[0]);
        end
        if (!saw_full) begin
            errors++;
            $display("ERROR: command queue never filled during the burst");
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/vec_backend_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module vec_backend_assertions (
    input logic                                clk,
    input logic                                rst_n,
    input logic [vec_cfg_pkg::issue_lanes-1:0] insts_valid,
    input logic [vec_cfg_pkg::issue_lanes-1:0] insts_ready,
    input logic                                rt_valid
);

    // Lane 1 may only be taken together with lane 0
    a_accept_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
        (insts_valid[1] && insts_ready[1]) |-> (insts_valid[0] && insts_ready[0]))
        else $error("lane 1 accepted without lane 0");

    // Ready ladder
    a_ready_ladder: assert property (@(posedge clk) disable iff (!rst_n)
        insts_ready[1] |-> insts_ready[0])
        else $error("insts_ready lane 1 high while lane 0 low");

    // Nothing in flight right after reset
    a_rt_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !rt_valid)
        else $error("rt_valid high in the first cycle after reset");

endmodule

`default_nettype wire

// File: design/vec_backend.sv
`timescale 1ns/100ps
`default_nettype none

module vec_backend #(
    parameter int cq_depth = vec_cfg_pkg::cq_depth_default
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic [vec_cfg_pkg::issue_lanes-1:0]                 insts_valid,
    input  vec_uop_pkg::vec_cmd_t [vec_cfg_pkg::issue_lanes-1:0] insts_cmd,
    output logic [vec_cfg_pkg::issue_lanes-1:0]                 insts_ready,
    output logic                                                rt_valid,
    output vec_cfg_pkg::vreg_idx_t                              rt_vd,
    output vec_cfg_pkg::vreg_t                                  rt_data
);

    // Queue to dispatch
    vec_uop_pkg::vec_cmd_t  head_cmd;
    logic                   cq_not_empty;
    logic                   cq_pop;

    // Dispatch to VRF
    vec_cfg_pkg::vreg_idx_t rd_idx1;
    vec_cfg_pkg::vreg_idx_t rd_idx2;
    vec_cfg_pkg::vreg_t     rd_data1;
    vec_cfg_pkg::vreg_t     rd_data2;

    alu_issue_if issue_bus ();

    cmd_queue #(
        .depth (cq_depth),
        .lanes (vec_cfg_pkg::issue_lanes)
    ) cmd_queue_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (insts_valid),
        .push_cmd   (insts_cmd),
        .push_ready (insts_ready),
        .head_cmd   (head_cmd),
        .not_empty  (cq_not_empty),
        .pop        (cq_pop)
    );

    // ALU writeback doubles as the hazard source
    vec_dispatch vec_dispatch_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .head_cmd  (head_cmd),
        .not_empty (cq_not_empty),
        .pop       (cq_pop),
        .rd_idx1   (rd_idx1),
        .rd_idx2   (rd_idx2),
        .rd_data1  (rd_data1),
        .rd_data2  (rd_data2),
        .ex_busy   (rt_valid),
        .ex_vd     (rt_vd),
        .issue     (issue_bus.dispatch_mp)
    );

    vec_alu vec_alu_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue_bus.alu_mp),
        .wr_valid (rt_valid),
        .wr_idx   (rt_vd),
        .wr_data  (rt_data)
    );

    vec_vrf vec_vrf_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_idx1  (rd_idx1),
        .rd_idx2  (rd_idx2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wr_valid (rt_valid),
        .wr_idx   (rt_vd),
        .wr_data  (rt_data)
    );

endmodule

`default_nettype wire

// File: design/vec_alu.sv
`timescale 1ns/100ps
`default_nettype none

module vec_alu (
    input  logic                   clk,
    input  logic                   rst_n,
    alu_issue_if.alu_mp            issue,
    output logic                   wr_valid,
    output vec_cfg_pkg::vreg_idx_t wr_idx,
    output vec_cfg_pkg::vreg_t     wr_data
);

    localparam int sew       = vec_cfg_pkg::sew;
    localparam int num_elems = vec_cfg_pkg::num_elems;

    vec_cfg_pkg::vreg_t result;

    // Byte lanes are independent, add and sub wrap
    always_comb begin
        for (int e = 0; e < num_elems; e++) begin
            case (issue.op)
                vec_uop_pkg::op_vadd:
                    result[e*sew +: sew] = issue.src2[e*sew +: sew] + issue.src1[e*sew +: sew];
                // vs2 minus vs1
                vec_uop_pkg::op_vsub:
                    result[e*sew +: sew] = issue.src2[e*sew +: sew] - issue.src1[e*sew +: sew];
                vec_uop_pkg::op_vand:
                    result[e*sew +: sew] = issue.src2[e*sew +: sew] & issue.src1[e*sew +: sew];
                vec_uop_pkg::op_vor:
                    result[e*sew +: sew] = issue.src2[e*sew +: sew] | issue.src1[e*sew +: sew];
                vec_uop_pkg::op_vxor:
                    result[e*sew +: sew] = issue.src2[e*sew +: sew] ^ issue.src1[e*sew +: sew];
                vec_uop_pkg::op_vmv_vx:
                    result[e*sew +: sew] = issue.scalar;
                default:
                    result[e*sew +: sew] = '0;
            endcase
        end
    end

    // Also the in-flight stage seen by dispatch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_valid <= 1'b0;
            wr_idx   <= '0;
            wr_data  <= '0;
        end else begin
            wr_valid <= issue.valid;
            wr_idx   <= issue.vd;
            wr_data  <= result;
        end
    end

endmodule

`default_nettype wire

// File: design/vec_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module vec_dispatch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  vec_uop_pkg::vec_cmd_t  head_cmd,
    input  logic                   not_empty,
    output logic                   pop,
    output vec_cfg_pkg::vreg_idx_t rd_idx1,
    output vec_cfg_pkg::vreg_idx_t rd_idx2,
    input  vec_cfg_pkg::vreg_t     rd_data1,
    input  vec_cfg_pkg::vreg_t     rd_data2,
    input  logic                   ex_busy,
    input  vec_cfg_pkg::vreg_idx_t ex_vd,
    alu_issue_if.dispatch_mp       issue
);

    logic uses_vs;
    logic vs1_busy;
    logic vs2_busy;
    logic hazard;

    // Splat takes no vector sources
    assign uses_vs = (head_cmd.op != vec_uop_pkg::op_vmv_vx);

    assign rd_idx1 = head_cmd.vs1;
    assign rd_idx2 = head_cmd.vs2;

    // Sources against both in-flight destinations.
    // The VRF write lands one edge after the ALU register, so both stages count.
    assign vs1_busy = (issue.valid && issue.vd == head_cmd.vs1) ||
                      (ex_busy && ex_vd == head_cmd.vs1);
    assign vs2_busy = (issue.valid && issue.vd == head_cmd.vs2) ||
                      (ex_busy && ex_vd == head_cmd.vs2);

    assign hazard = uses_vs && (vs1_busy || vs2_busy);
    assign pop    = not_empty && !hazard;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue.valid  <= 1'b0;
            issue.op     <= vec_uop_pkg::op_vadd;
            issue.vd     <= '0;
            issue.src1   <= '0;
            issue.src2   <= '0;
            issue.scalar <= '0;
        end else if (pop) begin
            issue.valid  <= 1'b1;
            issue.op     <= head_cmd.op;
            issue.vd     <= head_cmd.vd;
            issue.src1   <= rd_data1;
            issue.src2   <= rd_data2;
            issue.scalar <= head_cmd.scalar;
        end else begin
            // Bubble while stalled or empty
            issue.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/vec_vrf.sv
`timescale 1ns/100ps
`default_nettype none

module vec_vrf (
    input  logic                   clk,
    input  logic                   rst_n,
    input  vec_cfg_pkg::vreg_idx_t rd_idx1,
    input  vec_cfg_pkg::vreg_idx_t rd_idx2,
    output vec_cfg_pkg::vreg_t     rd_data1,
    output vec_cfg_pkg::vreg_t     rd_data2,
    input  logic                   wr_valid,
    input  vec_cfg_pkg::vreg_idx_t wr_idx,
    input  vec_cfg_pkg::vreg_t     wr_data
);

    vec_cfg_pkg::vreg_t regs [vec_cfg_pkg::num_vreg];

    // No bypass, a same-edge write is not visible here
    assign rd_data1 = regs[rd_idx1];
    assign rd_data2 = regs[rd_idx2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < vec_cfg_pkg::num_vreg; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_valid) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: design/cmd_queue.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_queue #(
    parameter int depth = 8,
    parameter int lanes = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [lanes-1:0]                  push_valid,
    input  vec_uop_pkg::vec_cmd_t [lanes-1:0] push_cmd,
    output logic [lanes-1:0]                  push_ready,
    output vec_uop_pkg::vec_cmd_t             head_cmd,
    output logic                              not_empty,
    input  logic                              pop
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    vec_uop_pkg::vec_cmd_t mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             active;
    logic [lanes-1:0] push_fire;
    logic [ptr_w-1:0] wr_slot [lanes];
    logic [cnt_w-1:0] push_num;
    logic             do_pop;

    // Circular pointer advance, step never exceeds depth
    function automatic logic [ptr_w-1:0] ptr_add(input logic [ptr_w-1:0] ptr,
                                                 input int unsigned      step);
        int unsigned sum;
        sum = ptr + step;
        if (sum >= depth) begin
            sum = sum - depth;
        end
        return ptr_w'(sum);
    endfunction

    // Ready ladder: lane i needs i+1 free slots
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            push_ready[i] = active && (int'(count) + i + 1 <= depth);
        end
    end

    assign push_fire = push_valid & push_ready;
    assign not_empty = (count != '0);
    assign do_pop    = pop && not_empty;
    assign head_cmd  = mem[rd_ptr];

    // Accepted lanes land in consecutive slots, lane 0 first
    always_comb begin
        int unsigned offset;
        offset = 0;
        for (int i = 0; i < lanes; i++) begin
            wr_slot[i] = ptr_add(wr_ptr, offset);
            if (push_fire[i]) begin
                offset = offset + 1;
            end
        end
        push_num = cnt_w'(offset);
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < lanes; i++) begin
            if (push_fire[i]) begin
                mem[wr_slot[i]] <= push_cmd[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            active <= 1'b0;
        end else begin
            // Holds ready low through reset
            active <= 1'b1;
            wr_ptr <= ptr_add(wr_ptr, push_num);
            if (do_pop) begin
                rd_ptr <= ptr_add(rd_ptr, 1);
            end
            count <= count + push_num - cnt_w'(do_pop);
        end
    end

endmodule

`default_nettype wire

// File: design/alu_issue_if.sv
`timescale 1ns/100ps
`default_nettype none

// One dispatched uop per cycle, the ALU never stalls
interface alu_issue_if;

    logic                   valid;
    vec_uop_pkg::vec_op_e   op;
    vec_cfg_pkg::vreg_idx_t vd;
    vec_cfg_pkg::vreg_t     src1;
    vec_cfg_pkg::vreg_t     src2;
    vec_cfg_pkg::elem_t     scalar;

    modport dispatch_mp (
        output valid,
        output op,
        output vd,
        output src1,
        output src2,
        output scalar
    );

    modport alu_mp (
        input valid,
        input op,
        input vd,
        input src1,
        input src2,
        input scalar
    );

endinterface

`default_nettype wire

// File: design/vec_uop_pkg.sv
`default_nettype none

package vec_uop_pkg;

    // Supported vector opcodes
    typedef enum logic [2:0] {
        op_vadd   = 3'd0,
        op_vsub   = 3'd1,
        op_vand   = 3'd2,
        op_vor    = 3'd3,
        op_vxor   = 3'd4,
        // Scalar splat, the only way to load values
        op_vmv_vx = 3'd5
    } vec_op_e;

    // Command as presented by the scalar front end, 26 bits
    typedef struct packed {
        vec_op_e               op;
        vec_cfg_pkg::vreg_idx_t vd;
        vec_cfg_pkg::vreg_idx_t vs1;
        vec_cfg_pkg::vreg_idx_t vs2;
        // Only meaningful for op_vmv_vx
        vec_cfg_pkg::elem_t     scalar;
    } vec_cmd_t;

endpackage

`default_nettype wire

// File: design/vec_cfg_pkg.sv
`default_nettype none

package vec_cfg_pkg;

    // Register file geometry
    parameter int vlen      = 128;
    parameter int sew       = 8;
    parameter int num_elems = vlen / sew;
    parameter int num_vreg  = 32;

    // Front end width and command queue sizing
    parameter int issue_lanes      = 2;
    parameter int cq_depth_default = 8;

    // One full vector register
    typedef logic [vlen-1:0] vreg_t;

    // Register index, 5 bits for 32 registers
    typedef logic [$clog2(num_vreg)-1:0] vreg_idx_t;

    // Single element, also used for scalar operands
    typedef logic [sew-1:0] elem_t;

endpackage

`default_nettype wire
